/* build.f */
logic/key_extract_pkg.sv
logic/ctrl_decoder.sv
logic/rule_tables.sv
logic/container_capture.sv
logic/key_assembler.sv
logic/key_extract_top.sv
bench/tb_key_extract.sv

/* Makefile */
SIM  := obj_dir/Vtb_key_extract
SRCS := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert --top-module tb_key_extract \
		-f build.f -o Vtb_key_extract

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/tb_key_extract.sv */
module tb_key_extract;

    // top bit of the comparator word of this stage
    localparam int op_hi = key_extract_pkg::op_top - key_extract_pkg::stage_id * 20;
    localparam logic [7:0] own_mod = {5'(key_extract_pkg::stage_id),
                                      3'(key_extract_pkg::key_ex_id)};
    // clock cycles of reset plus tests 1 to 5
    localparam int total_beats = 8 + 4 + 81 + 39 + 203 + 36;

    logic                        clk;
    logic                        rst_n;
    key_extract_pkg::phv_t       phv_in;
    logic                        phv_valid_in;
    key_extract_pkg::ctrl_data_t ctrl_in_data;
    logic                        ctrl_in_valid;
    logic                        ctrl_in_last;
    key_extract_pkg::phv_t       phv_out;
    logic                        phv_valid_out;
    key_extract_pkg::key_t       key_out;
    logic                        key_valid_out;
    key_extract_pkg::key_t       key_mask_out;
    key_extract_pkg::ctrl_data_t ctrl_out_data;
    logic                        ctrl_out_valid;
    logic                        ctrl_out_last;

    // table copy and control FSM model
    key_extract_pkg::key_off_t off_tbl  [16];
    key_extract_pkg::key_t     mask_tbl [16];
    logic                      in_write = 1'b0;
    logic                      write_mask_sel = 1'b0;
    key_extract_pkg::tenant_t  model_row = '0;

    // expected pipeline where entry 1 is due at the next check
    key_extract_pkg::phv_t       exp_phv  [2] = '{'0, '0};
    logic                        exp_pv   [2] = '{1'b0, 1'b0};
    key_extract_pkg::key_t       exp_key  [2] = '{'0, '0};
    key_extract_pkg::key_t       exp_mask [2] = '{'0, '0};
    key_extract_pkg::ctrl_data_t exp_cd = '0;
    logic                        exp_cv = 1'b0;
    logic                        exp_cl = 1'b0;

    int pass_cnt = 0;
    int fail_cnt = 0;
    int test_mark = 0;

    key_extract_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_eq(string name, key_extract_pkg::phv_t exp,
                            key_extract_pkg::phv_t got);
        assert (got === exp) pass_cnt++;
        else begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    function automatic key_extract_pkg::phv_t rand_phv(key_extract_pkg::tenant_t t);
        logic [1151:0]         r;
        key_extract_pkg::phv_t p;
        for (int i = 0; i < 36; i++) begin
            r[i*32 +: 32] = $urandom;
        end
        p = r[key_extract_pkg::phv_len-1:0];
        p[key_extract_pkg::tenant_lo +: key_extract_pkg::tenant_w] = t;
        return p;
    endfunction

    function automatic key_extract_pkg::ctrl_data_t rand_ctrl();
        key_extract_pkg::ctrl_data_t c;
        for (int i = 0; i < 16; i++) begin
            c[i*32 +: 32] = $urandom;
        end
        return c;
    endfunction

    // lowest phv bit of a container given its size code and index
    function automatic int cont_low(logic [1:0] code, key_extract_pkg::cont_sel_t idx);
        int top4;
        int top2;
        top4 = key_extract_pkg::cont_6b_top - 8 * 48;
        top2 = top4 - 8 * 32;
        case (code)
            2'b10:   return key_extract_pkg::cont_6b_top - (7 - int'(idx)) * 48 - 47;
            2'b01:   return top4 - (7 - int'(idx)) * 32 - 31;
            default: return top2 - (7 - int'(idx)) * 16 - 15;
        endcase
    endfunction

    function automatic logic [7:0] operand_byte(key_extract_pkg::phv_t p, logic [8:0] desc);
        if (desc[8]) begin
            return desc[7:0];
        end
        if (desc[4:3] == 2'b11) begin
            return 8'h00;
        end
        return p[cont_low(desc[4:3], desc[2:0]) +: 8];
    endfunction

    // expected key and mask of one valid phv
    function automatic void ref_result(input key_extract_pkg::phv_t p,
                                       output key_extract_pkg::key_t key,
                                       output key_extract_pkg::key_t mask);
        key_extract_pkg::tenant_t  t;
        key_extract_pkg::key_off_t off;
        logic [19:0]               w;
        logic [7:0]                o1;
        logic [7:0]                o2;
        logic                      flag;
        t = p[key_extract_pkg::tenant_lo +: key_extract_pkg::tenant_w];
        off = off_tbl[t];
        w = p[op_hi -: 20];
        o1 = operand_byte(p, w[17:9]);
        o2 = operand_byte(p, w[8:0]);
        case (w[19:18])
            2'b00:   flag = o1 > o2;
            2'b01:   flag = o1 >= o2;
            2'b10:   flag = o1 == o2;
            default: flag = 1'b1;
        endcase
        key = {p[cont_low(2'b10, off[17:15]) +: 48], p[cont_low(2'b10, off[14:12]) +: 48],
               p[cont_low(2'b01, off[11:9]) +: 32], p[cont_low(2'b01, off[8:6]) +: 32],
               p[cont_low(2'b00, off[5:3]) +: 16], p[cont_low(2'b00, off[2:0]) +: 16],
               5'b00000};
        key[4 - key_extract_pkg::stage_id] = flag;
        mask = mask_tbl[t];
    endfunction

    function automatic key_extract_pkg::ctrl_data_t swap_bytes(key_extract_pkg::ctrl_data_t d);
        key_extract_pkg::ctrl_data_t s;
        for (int i = 0; i < 64; i++) begin
            s[i*8 +: 8] = d[(63 - i)*8 +: 8];
        end
        return s;
    endfunction

    // control rules applied to the beat the DUT takes at the next edge
    task automatic model_ctrl_beat();
        key_extract_pkg::ctrl_data_t sw;
        logic                        hdr;
        hdr = ctrl_in_valid && (ctrl_in_data[key_extract_pkg::mod_id_lo +: 8] == own_mod)
              && (ctrl_in_data[key_extract_pkg::flag_lo +: 16] == key_extract_pkg::ctrl_flag_key);
        exp_cd = '0;
        exp_cv = 1'b0;
        exp_cl = 1'b0;
        if (!in_write) begin
            if (!hdr) begin
                exp_cd = ctrl_in_data;
                exp_cv = ctrl_in_valid;
                exp_cl = ctrl_in_last;
            end else if (!ctrl_in_last) begin
                in_write = 1'b1;
                write_mask_sel = ctrl_in_data[key_extract_pkg::resv_lo +: 4] != 4'd0;
                model_row = ctrl_in_data[key_extract_pkg::index_lo +: 4];
            end
        end else if (ctrl_in_valid) begin
            sw = swap_bytes(ctrl_in_data);
            if (write_mask_sel) begin
                mask_tbl[model_row] = sw[511 -: 197];
            end else begin
                off_tbl[model_row] = sw[511 -: 18];
            end
            model_row = model_row + 1'b1;
            if (ctrl_in_last) begin
                in_write = 1'b0;
            end
        end
    endtask

    // outputs are compared at the falling edge where they are stable
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            check_eq("phv_out", exp_phv[1], phv_out);
            check_eq("phv_valid_out", key_extract_pkg::phv_t'(exp_pv[1]),
                     key_extract_pkg::phv_t'(phv_valid_out));
            check_eq("key_valid_out", key_extract_pkg::phv_t'(exp_pv[1]),
                     key_extract_pkg::phv_t'(key_valid_out));
            check_eq("key_out", key_extract_pkg::phv_t'(exp_key[1]),
                     key_extract_pkg::phv_t'(key_out));
            check_eq("key_mask_out", key_extract_pkg::phv_t'(exp_mask[1]),
                     key_extract_pkg::phv_t'(key_mask_out));
            check_eq("ctrl_out_data", key_extract_pkg::phv_t'(exp_cd),
                     key_extract_pkg::phv_t'(ctrl_out_data));
            check_eq("ctrl_out_valid", key_extract_pkg::phv_t'(exp_cv),
                     key_extract_pkg::phv_t'(ctrl_out_valid));
            check_eq("ctrl_out_last", key_extract_pkg::phv_t'(exp_cl),
                     key_extract_pkg::phv_t'(ctrl_out_last));
            exp_phv[1]  = exp_phv[0];
            exp_pv[1]   = exp_pv[0];
            exp_key[1]  = exp_key[0];
            exp_mask[1] = exp_mask[0];
            exp_phv[0]  = phv_in;
            exp_pv[0]   = phv_valid_in;
            exp_key[0]  = '0;
            exp_mask[0] = '0;
            // table read uses the rows before this beat's write
            if (phv_valid_in) begin
                ref_result(phv_in, exp_key[0], exp_mask[0]);
            end
            model_ctrl_beat();
        end
    end

    task automatic send_beat(key_extract_pkg::ctrl_data_t d, logic v, logic l);
        ctrl_in_data = d;
        ctrl_in_valid = v;
        ctrl_in_last = l;
        @(posedge clk);
        #1;
    endtask

    task automatic drive_phv(key_extract_pkg::phv_t p, logic v);
        phv_in = p;
        phv_valid_in = v;
        @(posedge clk);
        #1;
    endtask

    function automatic key_extract_pkg::ctrl_data_t make_header(logic [7:0] mod,
            logic [15:0] flag, logic [3:0] resv, logic [3:0] index);
        key_extract_pkg::ctrl_data_t h;
        h = rand_ctrl();
        h[key_extract_pkg::mod_id_lo +: 8] = mod;
        h[key_extract_pkg::flag_lo +: 16] = flag;
        h[key_extract_pkg::resv_lo +: 4] = resv;
        // upper index bits are ignored by the DUT
        h[key_extract_pkg::index_lo +: 8] = {4'($urandom), index};
        return h;
    endfunction

    task automatic send_table_packet(logic is_mask, logic [3:0] start, int rows, logic gaps);
        logic [3:0] resv;
        resv = is_mask ? 4'(1 + $urandom % 15) : 4'd0;
        send_beat(make_header(own_mod, key_extract_pkg::ctrl_flag_key, resv, start), 1'b1, 1'b0);
        for (int r = 0; r < rows; r++) begin
            if (gaps && (r % 3 == 1)) begin
                send_beat(rand_ctrl(), 1'b0, 1'b0);
            end
            send_beat(rand_ctrl(), 1'b1, r == rows - 1);
        end
        send_beat(rand_ctrl(), 1'b0, 1'b0);
    endtask

    task automatic send_foreign(logic [7:0] mod, logic [15:0] flag);
        send_beat(make_header(mod, flag, 4'd0, 4'd0), 1'b1, 1'b0);
        send_beat(rand_ctrl(), 1'b1, 1'b0);
        send_beat(rand_ctrl(), 1'b1, 1'b1);
        send_beat(rand_ctrl(), 1'b0, 1'b0);
    endtask

    task automatic end_test(string name);
        phv_valid_in = 1'b0;
        ctrl_in_valid = 1'b0;
        ctrl_in_last = 1'b0;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        $display("%s finished, %0d errors", name, fail_cnt - test_mark);
        test_mark = fail_cnt;
    endtask

    task automatic run_compare_cases();
        key_extract_pkg::phv_t p;
        logic [8:0]            d1;
        logic [8:0]            d2;
        logic [7:0]            a;
        logic [7:0]            b;
        logic [1:0]            codes [3];
        int                    s1;
        int                    i1;
        codes = '{2'b10, 2'b01, 2'b00};
        for (int op = 0; op < 4; op++) begin
            for (int mode = 0; mode < 3; mode++) begin
                // rel picks operand one equal to, greater than or smaller than operand two
                for (int rel = 0; rel < 3; rel++) begin
                    p = rand_phv(4'($urandom));
                    a = 8'(1 + $urandom % 254);
                    b = (rel == 0) ? a : ((rel == 1) ? a - 8'd1 : a + 8'd1);
                    s1 = $urandom % 3;
                    i1 = $urandom % 8;
                    d1 = {1'b1, a};
                    d2 = {1'b1, b};
                    if (mode != 0) begin
                        d1 = {1'b0, 3'($urandom), codes[s1], 3'(i1)};
                        p[cont_low(codes[s1], 3'(i1)) +: 8] = a;
                    end
                    if (mode == 2) begin
                        d2 = {1'b0, 3'($urandom), codes[(s1 + 1) % 3], 3'(7 - i1)};
                        p[cont_low(codes[(s1 + 1) % 3], 3'(7 - i1)) +: 8] = b;
                    end
                    p[op_hi -: 20] = {2'(op), d1, d2};
                    drive_phv(p, 1'b1);
                end
            end
        end
    endtask

    // stimulus
    initial begin
        void'($urandom(32'h8fec));
        rst_n = 1'b0;
        phv_in = '0;
        phv_valid_in = 1'b0;
        ctrl_in_data = '0;
        ctrl_in_valid = 1'b0;
        ctrl_in_last = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (3) begin
            @(negedge clk);
            check_eq("phv_valid_out", '0, key_extract_pkg::phv_t'(phv_valid_out));
            check_eq("key_valid_out", '0, key_extract_pkg::phv_t'(key_valid_out));
            check_eq("ctrl_out_valid", '0, key_extract_pkg::phv_t'(ctrl_out_valid));
            check_eq("key_out", '0, key_extract_pkg::phv_t'(key_out));
            check_eq("key_mask_out", '0, key_extract_pkg::phv_t'(key_mask_out));
            check_eq("ctrl_out_data", '0, key_extract_pkg::phv_t'(ctrl_out_data));
            @(posedge clk);
            #1;
        end
        $display("reset values finished, %0d errors", fail_cnt - test_mark);
        test_mark = fail_cnt;

        send_table_packet(1'b0, 4'd0, 10, 1'b1);
        send_table_packet(1'b0, 4'd10, 6, 1'b0);
        // starts at row 8 and wraps around to row 7
        send_table_packet(1'b1, 4'd8, 16, 1'b1);
        for (int t = 0; t < 16; t++) begin
            drive_phv(rand_phv(4'(t)), 1'b1);
        end
        for (int t = 0; t < 16; t++) begin
            drive_phv(rand_phv(4'($urandom)), 1'b1);
        end
        end_test("table writes and keys");

        run_compare_cases();
        end_test("comparator opcodes");

        for (int c = 0; c < 200; c++) begin
            drive_phv(rand_phv(4'($urandom)), ($urandom % 8) != 0);
        end
        end_test("random back to back phvs");

        send_foreign({5'(key_extract_pkg::stage_id + 1), 3'(key_extract_pkg::key_ex_id)},
                     key_extract_pkg::ctrl_flag_key);
        send_foreign({5'(key_extract_pkg::stage_id), 3'(key_extract_pkg::key_ex_id + 1)},
                     key_extract_pkg::ctrl_flag_key);
        send_foreign(own_mod, key_extract_pkg::ctrl_flag_key ^ 16'h0001);
        send_table_packet(1'b1, 4'd5, 2, 1'b1);
        for (int t = 0; t < 16; t++) begin
            drive_phv(rand_phv(4'(t)), 1'b1);
        end
        end_test("control forwarding");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(total_beats * 10 + 1000);
        $display("timeout, the tests did not complete in the expected time");
        $display("Test FAILED");
        $finish;
    end

endmodule

/* logic/key_extract_top.sv */
module key_extract_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  key_extract_pkg::phv_t       phv_in,
    input  logic                        phv_valid_in,
    input  key_extract_pkg::ctrl_data_t ctrl_in_data,
    input  logic                        ctrl_in_valid,
    input  logic                        ctrl_in_last,
    output key_extract_pkg::phv_t       phv_out,
    output logic                        phv_valid_out,
    output key_extract_pkg::key_t       key_out,
    output logic                        key_valid_out,
    output key_extract_pkg::key_t       key_mask_out,
    output key_extract_pkg::ctrl_data_t ctrl_out_data,
    output logic                        ctrl_out_valid,
    output logic                        ctrl_out_last
);

    // table write port
    logic                        wr_off;
    logic                        wr_mask;
    key_extract_pkg::tenant_t    wr_index;
    key_extract_pkg::ctrl_data_t wr_data;

    // table read data, aligned with stage one
    key_extract_pkg::key_off_t key_off;
    key_extract_pkg::key_t     key_mask;

    // stage one outputs
    key_extract_pkg::phv_t     cap_phv;
    logic                      cap_valid;
    key_extract_pkg::cont_2b_t cont_2b [key_extract_pkg::n_cont];
    key_extract_pkg::cont_4b_t cont_4b [key_extract_pkg::n_cont];
    key_extract_pkg::cont_6b_t cont_6b [key_extract_pkg::n_cont];
    logic                      cmp_flag;

    ctrl_decoder u_ctrl_decoder (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_in_data   (ctrl_in_data),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_last   (ctrl_in_last),
        .ctrl_out_data  (ctrl_out_data),
        .ctrl_out_valid (ctrl_out_valid),
        .ctrl_out_last  (ctrl_out_last),
        .wr_off         (wr_off),
        .wr_mask        (wr_mask),
        .wr_index       (wr_index),
        .wr_data        (wr_data)
    );

    // tenant comes straight from the incoming vlan id
    rule_tables u_rule_tables (
        .clk       (clk),
        .wr_off    (wr_off),
        .wr_mask   (wr_mask),
        .wr_index  (wr_index),
        .wr_data   (wr_data),
        .rd_tenant (phv_in[key_extract_pkg::tenant_lo +: key_extract_pkg::tenant_w]),
        .key_off   (key_off),
        .key_mask  (key_mask)
    );

    container_capture u_container_capture (
        .clk          (clk),
        .rst_n        (rst_n),
        .phv_in       (phv_in),
        .phv_valid_in (phv_valid_in),
        .cap_phv      (cap_phv),
        .cap_valid    (cap_valid),
        .cont_2b      (cont_2b),
        .cont_4b      (cont_4b),
        .cont_6b      (cont_6b),
        .cmp_flag     (cmp_flag)
    );

    key_assembler u_key_assembler (
        .clk           (clk),
        .rst_n         (rst_n),
        .cap_phv       (cap_phv),
        .cap_valid     (cap_valid),
        .cont_2b       (cont_2b),
        .cont_4b       (cont_4b),
        .cont_6b       (cont_6b),
        .cmp_flag      (cmp_flag),
        .key_off       (key_off),
        .key_mask      (key_mask),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

/* logic/key_assembler.sv */
module key_assembler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     cap_phv,
    input  logic                      cap_valid,
    input  key_extract_pkg::cont_2b_t cont_2b [key_extract_pkg::n_cont],
    input  key_extract_pkg::cont_4b_t cont_4b [key_extract_pkg::n_cont],
    input  key_extract_pkg::cont_6b_t cont_6b [key_extract_pkg::n_cont],
    input  logic                      cmp_flag,
    input  key_extract_pkg::key_off_t key_off,
    input  key_extract_pkg::key_t     key_mask,
    output key_extract_pkg::phv_t     phv_out,
    output logic                      phv_valid_out,
    output key_extract_pkg::key_t     key_out,
    output logic                      key_valid_out,
    output key_extract_pkg::key_t     key_mask_out
);

    key_extract_pkg::cont_sel_t sel [6];
    key_extract_pkg::key_t      key_next;
    logic [4:0]                 cmp_bits;

    // offset row holds six selects, 6B pair first
    for (genvar k = 0; k < 6; k++) begin : g_sel
        assign sel[k] = key_off[key_extract_pkg::off_len - 1
                                - k * $bits(key_extract_pkg::cont_sel_t)
                                -: $bits(key_extract_pkg::cont_sel_t)];
    end

    // one comparator bit per stage, stage 0 at bit 4
    always_comb begin
        cmp_bits = '0;
        cmp_bits[4 - key_extract_pkg::stage_id] = cmp_flag;
    end

    assign key_next = {cont_6b[sel[0]], cont_6b[sel[1]],
                       cont_4b[sel[2]], cont_4b[sel[3]],
                       cont_2b[sel[4]], cont_2b[sel[5]],
                       cmp_bits};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phv_out       <= '0;
            phv_valid_out <= 1'b0;
            key_out       <= '0;
            key_valid_out <= 1'b0;
            key_mask_out  <= '0;
        end else begin
            // phv passes through whether valid or not
            phv_out       <= cap_phv;
            phv_valid_out <= cap_valid;
            if (cap_valid) begin
                key_out       <= key_next;
                key_valid_out <= 1'b1;
                key_mask_out  <= key_mask;
            end else begin
                key_out       <= '0;
                key_valid_out <= 1'b0;
                key_mask_out  <= '0;
            end
        end
    end

endmodule

/* logic/container_capture.sv */
module container_capture (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     phv_in,
    input  logic                      phv_valid_in,
    output key_extract_pkg::phv_t     cap_phv,
    output logic                      cap_valid,
    output key_extract_pkg::cont_2b_t cont_2b [key_extract_pkg::n_cont],
    output key_extract_pkg::cont_4b_t cont_4b [key_extract_pkg::n_cont],
    output key_extract_pkg::cont_6b_t cont_6b [key_extract_pkg::n_cont],
    output logic                      cmp_flag
);

    key_extract_pkg::cont_2b_t in_2b [key_extract_pkg::n_cont];
    key_extract_pkg::cont_4b_t in_4b [key_extract_pkg::n_cont];
    key_extract_pkg::cont_6b_t in_6b [key_extract_pkg::n_cont];

    key_extract_pkg::cmp_op_t op_word;
    logic [7:0]               opnd_1;
    logic [7:0]               opnd_2;
    logic                     cmp_next;

    // containers of each size, index 7 highest in the phv
    for (genvar i = 0; i < key_extract_pkg::n_cont; i++) begin : g_slice
        assign in_6b[i] = phv_in[key_extract_pkg::cont_6b_top
                                 - (key_extract_pkg::n_cont - 1 - i) * key_extract_pkg::w_6b
                                 -: key_extract_pkg::w_6b];
        assign in_4b[i] = phv_in[key_extract_pkg::cont_6b_top
                                 - key_extract_pkg::n_cont * key_extract_pkg::w_6b
                                 - (key_extract_pkg::n_cont - 1 - i) * key_extract_pkg::w_4b
                                 -: key_extract_pkg::w_4b];
        assign in_2b[i] = phv_in[key_extract_pkg::cont_6b_top
                                 - key_extract_pkg::n_cont
                                   * (key_extract_pkg::w_6b + key_extract_pkg::w_4b)
                                 - (key_extract_pkg::n_cont - 1 - i) * key_extract_pkg::w_2b
                                 -: key_extract_pkg::w_2b];
    end

    // comparator word owned by this stage
    assign op_word = phv_in[key_extract_pkg::op_top
                            - key_extract_pkg::stage_id * $bits(key_extract_pkg::cmp_op_t)
                            -: $bits(key_extract_pkg::cmp_op_t)];

    // desc[8] picks the immediate, else size in 4:3 and index in 2:0
    function automatic logic [7:0] resolve_operand(input logic [8:0] desc);
        logic [7:0]                 val;
        key_extract_pkg::cont_sel_t sel;
        sel = desc[2:0];
        if (desc[8]) begin
            val = desc[7:0];
        end else begin
            case (desc[4:3])
                2'b10:   val = in_6b[sel][7:0];
                2'b01:   val = in_4b[sel][7:0];
                2'b00:   val = in_2b[sel][7:0];
                default: val = 8'h00;
            endcase
        end
        return val;
    endfunction

    always_comb begin
        opnd_1 = resolve_operand(op_word[17:9]);
        opnd_2 = resolve_operand(op_word[8:0]);
        case (op_word[19:18])
            2'b00:   cmp_next = (opnd_1 > opnd_2);
            2'b01:   cmp_next = (opnd_1 >= opnd_2);
            2'b10:   cmp_next = (opnd_1 == opnd_2);
            default: cmp_next = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= phv_valid_in;
        end
    end

    // stage one payload
    always_ff @(posedge clk) begin
        cap_phv  <= phv_in;
        cont_2b  <= in_2b;
        cont_4b  <= in_4b;
        cont_6b  <= in_6b;
        cmp_flag <= cmp_next;
    end

endmodule

/* logic/rule_tables.sv */
module rule_tables (
    input  logic                        clk,
    input  logic                        wr_off,
    input  logic                        wr_mask,
    input  key_extract_pkg::tenant_t    wr_index,
    input  key_extract_pkg::ctrl_data_t wr_data,
    input  key_extract_pkg::tenant_t    rd_tenant,
    output key_extract_pkg::key_off_t   key_off,
    output key_extract_pkg::key_t       key_mask
);

    // one row per tenant
    key_extract_pkg::key_off_t off_mem  [key_extract_pkg::table_depth];
    key_extract_pkg::key_t     mask_mem [key_extract_pkg::table_depth];

    key_extract_pkg::key_off_t off_row;
    key_extract_pkg::key_t     mask_row;

    // rows are taken from the top of the byte-swapped beat
    assign off_row  = wr_data[key_extract_pkg::ctrl_data_w - 1 -: key_extract_pkg::off_len];
    assign mask_row = wr_data[key_extract_pkg::ctrl_data_w - 1 -: key_extract_pkg::key_len];

    // write port, control side
    always_ff @(posedge clk) begin
        if (wr_off) begin
            off_mem[wr_index] <= off_row;
        end
        if (wr_mask) begin
            mask_mem[wr_index] <= mask_row;
        end
    end

    // read port, phv side
    // same-row collision returns the old contents
    always_ff @(posedge clk) begin
        key_off  <= off_mem[rd_tenant];
        key_mask <= mask_mem[rd_tenant];
    end

endmodule

/* logic/ctrl_decoder.sv */
module ctrl_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  key_extract_pkg::ctrl_data_t ctrl_in_data,
    input  logic                        ctrl_in_valid,
    input  logic                        ctrl_in_last,
    output key_extract_pkg::ctrl_data_t ctrl_out_data,
    output logic                        ctrl_out_valid,
    output logic                        ctrl_out_last,
    output logic                        wr_off,
    output logic                        wr_mask,
    output key_extract_pkg::tenant_t    wr_index,
    output key_extract_pkg::ctrl_data_t wr_data
);

    key_extract_pkg::ctrl_state_t state;
    key_extract_pkg::tenant_t     row_cnt;
    key_extract_pkg::tenant_t     start_row;

    logic [7:0]  mod_id;
    logic [3:0]  resv;
    logic [15:0] ctrl_flag;
    logic        hdr_match;

    // header fields
    assign mod_id    = ctrl_in_data[key_extract_pkg::mod_id_lo +: 8];
    assign resv      = ctrl_in_data[key_extract_pkg::resv_lo +: 4];
    assign ctrl_flag = ctrl_in_data[key_extract_pkg::flag_lo +: 16];
    // index field is 8 bits wide, the table only has 16 rows
    assign start_row = ctrl_in_data[key_extract_pkg::index_lo +: key_extract_pkg::tenant_w];

    // module id carries stage in the upper 5 bits, block id in the lower 3
    assign hdr_match = ctrl_in_valid
                    && (mod_id[7:3] == 5'(key_extract_pkg::stage_id))
                    && (mod_id[2:0] == 3'(key_extract_pkg::key_ex_id))
                    && (ctrl_flag == key_extract_pkg::ctrl_flag_key);

    // byte 0 of the beat becomes the most significant byte
    always_comb begin
        for (int b = 0; b < key_extract_pkg::ctrl_data_w / 8; b++) begin
            wr_data[key_extract_pkg::ctrl_data_w - 1 - 8 * b -: 8] = ctrl_in_data[8 * b +: 8];
        end
    end

    // each valid beat after the header writes one row
    assign wr_off   = (state == key_extract_pkg::write_off) && ctrl_in_valid;
    assign wr_mask  = (state == key_extract_pkg::write_mask) && ctrl_in_valid;
    assign wr_index = row_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= key_extract_pkg::idle;
            row_cnt <= '0;
        end else begin
            case (state)
                key_extract_pkg::idle: begin
                    // a header that is also last carries no rows
                    if (hdr_match && !ctrl_in_last) begin
                        row_cnt <= start_row;
                        if (resv == 4'd0) begin
                            state <= key_extract_pkg::write_off;
                        end else begin
                            state <= key_extract_pkg::write_mask;
                        end
                    end
                end
                key_extract_pkg::write_off,
                key_extract_pkg::write_mask: begin
                    if (ctrl_in_valid) begin
                        row_cnt <= row_cnt + 1'b1;
                        if (ctrl_in_last) begin
                            state <= key_extract_pkg::idle;
                        end
                    end
                end
                default: begin
                    state <= key_extract_pkg::idle;
                end
            endcase
        end
    end

    // forward everything seen in idle except our own header
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_out_data  <= '0;
            ctrl_out_valid <= 1'b0;
            ctrl_out_last  <= 1'b0;
        end else if ((state == key_extract_pkg::idle) && !hdr_match) begin
            ctrl_out_data  <= ctrl_in_data;
            ctrl_out_valid <= ctrl_in_valid;
            ctrl_out_last  <= ctrl_in_last;
        end else begin
            // table write packets are consumed here
            ctrl_out_data  <= '0;
            ctrl_out_valid <= 1'b0;
            ctrl_out_last  <= 1'b0;
        end
    end

endmodule

/* logic/key_extract_pkg.sv */
package key_extract_pkg;

    // datapath widths
    localparam int phv_len     = 1124;
    localparam int key_len     = 197;
    localparam int ctrl_data_w = 512;

    // container widths and count per size
    localparam int w_2b   = 16;
    localparam int w_4b   = 32;
    localparam int w_6b   = 48;
    localparam int n_cont = 8;

    // offset row is six 3-bit container selects
    localparam int off_len     = 18;
    localparam int tenant_w    = 4;
    localparam int table_depth = 16;

    // phv layout, six-byte containers at the top, then 4B, then 2B
    localparam int cont_6b_top = 1123;
    // five 20-bit comparator words, word 0 highest
    localparam int op_top      = 355;
    // tenant is vlan id bits 7:4
    localparam int tenant_lo   = 133;

    // identity of this block in the pipeline
    localparam int stage_id  = 0;
    localparam int key_ex_id = 1;

    localparam logic [15:0] ctrl_flag_key = 16'hf2f1;

    // control header fields, positions in the raw beat
    localparam int mod_id_lo = 368;
    localparam int resv_lo   = 380;
    localparam int flag_lo   = 320;
    localparam int index_lo  = 384;

    typedef logic [phv_len-1:0]     phv_t;
    typedef logic [key_len-1:0]     key_t;
    typedef logic [off_len-1:0]     key_off_t;
    typedef logic [tenant_w-1:0]    tenant_t;
    typedef logic [ctrl_data_w-1:0] ctrl_data_t;

    typedef logic [w_2b-1:0] cont_2b_t;
    typedef logic [w_4b-1:0] cont_4b_t;
    typedef logic [w_6b-1:0] cont_6b_t;

    typedef logic [2:0]  cont_sel_t;
    // opcode 19:18, operand one 17:9, operand two 8:0
    typedef logic [19:0] cmp_op_t;

    // table write FSM
    typedef enum logic [1:0] {
        idle,
        write_off,
        write_mask
    } ctrl_state_t;

endpackage
